//--- Bender.yml
package:
  name: gremlin

sources:
  - files:
      - hdl/gremlin_pkg.sv
      - hdl/gremlin_mem_if.sv
      - hdl/gremlin_ram.sv
      - hdl/gremlin_host_port.sv
      - hdl/gremlin_seq.sv
      - hdl/gremlin_datapath.sv
      - hdl/gremlin_carousel.sv
      - hdl/gremlin_top.sv
  - target: test
    files:
      - verification/gremlin_tb.sv

//--- flist.f
hdl/gremlin_pkg.sv
hdl/gremlin_mem_if.sv
hdl/gremlin_ram.sv
hdl/gremlin_host_port.sv
hdl/gremlin_seq.sv
hdl/gremlin_datapath.sv
hdl/gremlin_carousel.sv
hdl/gremlin_top.sv
verification/gremlin_tb.sv

//--- hdl/gremlin_carousel.sv
`timescale 1ns/1ps

module gremlin_carousel #(
  parameter int SLOT_LEN = 192
) (
  input  logic CLK,
  input  logic RST,
  input  logic host_busy_i,
  output logic refresh_o
);

  localparam int SLOT_W = $clog2(SLOT_LEN);

  logic [SLOT_W-1:0] slot;
  logic [3:0]        frame;
  logic [1:0]        refresh_req, refresh_ack;  // pending when they differ
  logic              slot_wrap, refresh_due;

  assign slot_wrap   = (slot == SLOT_W'(SLOT_LEN - 1));
  assign refresh_due = (slot == '0) && frame[0];  // odd frames only

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      slot        <= '0;
      frame       <= '0;
      refresh_req <= '0;
      refresh_ack <= '0;
      refresh_o   <= 1'b0;
    end
    else
    begin
      if (slot_wrap)
      begin
        slot  <= '0;
        frame <= frame + 1'b1;
      end
      else
        slot <= slot + 1'b1;

      if (refresh_due)
        refresh_req <= refresh_req + 1'b1;

      // one toggle per request, held off by host bursts
      if ((refresh_req != refresh_ack) && !host_busy_i)
      begin
        refresh_ack <= refresh_ack + 1'b1;
        refresh_o   <= !refresh_o;
      end
    end
  end

endmodule

//--- hdl/gremlin_datapath.sv
`timescale 1ns/1ps

module gremlin_datapath (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           adv_i,
  input  gremlin_pkg::instr_t            instr_op_i,
  input  gremlin_pkg::instr_t            instr_ex_i,
  mem_port_if.dp_mp                      mem,
  input  logic                           capture_i,
  input  gremlin_pkg::word_t             in_0_i,
  input  gremlin_pkg::word_t             in_1_i,
  input  gremlin_pkg::word_t             in_2_i,
  input  gremlin_pkg::word_t             in_3_i,
  output gremlin_pkg::word_t             out_0_o,
  output gremlin_pkg::word_t             out_1_o,
  output gremlin_pkg::word_t             out_2_o,
  output gremlin_pkg::word_t             out_3_o,
  output logic                           acc_nz_o,
  output logic [gremlin_pkg::ADDR_W-1:0] index_o
);
  import gremlin_pkg::*;

  word_t             acc, operand, op_sel, sum;
  word_t             in_q [4];
  word_t             out_q [4];
  logic              carry, cin, save_carry;
  logic [ADDR_W-1:0] index;

  always_comb
  begin
    case (instr_op_i.osel)
      OSEL_MEM:  op_sel = mem.rdata;
      OSEL_INV:  op_sel = ~mem.rdata;
      OSEL_ZERO: op_sel = '0;
      OSEL_ONES: op_sel = '1;
      default:   op_sel = '0;
    endcase
  end

  always_comb
  begin
    case (instr_ex_i.op)
      OP_ADC1: cin = 1'b1;
      OP_ADDC: cin = save_carry;
      default: cin = 1'b0;
    endcase
  end

  assign {carry, sum} = 17'(acc) + 17'(operand) + 17'(cin);

  assign mem.wdata = acc;  // store data
  assign acc_nz_o  = (acc != '0);
  assign index_o   = index;
  assign out_0_o   = out_q[0];
  assign out_1_o   = out_q[1];
  assign out_2_o   = out_q[2];
  assign out_3_o   = out_q[3];

  // ------------------------------------------------------------
  // execute
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      acc        <= '0;
      save_carry <= 1'b0;
      index      <= '0;
      out_q      <= '{default: '0};
    end
    else if (adv_i)
    begin
      case (instr_ex_i.op)
        OP_ADD, OP_ADC1, OP_ADDC:
        begin
          acc        <= sum;
          save_carry <= carry;
        end
        OP_LDIN:   acc <= in_q[instr_ex_i.imm[1:0]];
        OP_OUT:    out_q[instr_ex_i.imm[1:0]] <= acc;
        OP_SETIDX: index <= acc[ADDR_W-1:0];
        OP_AND:    acc <= acc & operand;
        OP_OR:     acc <= acc | operand;
        OP_XOR:    acc <= acc ^ operand;
        default:   ;  // halt, store and no-ops
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (adv_i)
      operand <= op_sel;  // latched at the operand stage
    if (capture_i)
    begin
      in_q[0] <= in_0_i;
      in_q[1] <= in_1_i;
      in_q[2] <= in_2_i;
      in_q[3] <= in_3_i;
    end
  end

endmodule

//--- hdl/gremlin_host_port.sv
`timescale 1ns/1ps

module gremlin_host_port (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           host_read_i,
  input  logic                           host_write_i,
  input  logic [3:0]                     host_addr_i,
  input  logic [63:0]                    host_wdata_i,
  output logic [31:0]                    host_rdata_o,
  output logic                           host_read_ack_o,
  output logic                           host_write_ack_o,
  output logic                           host_busy_o,
  output logic                           prog_we_o,
  output logic [gremlin_pkg::ADDR_W-1:0] prog_waddr_o,
  output gremlin_pkg::instr_t            prog_wdata_o,
  mem_port_if.arb_mp                     mem,
  output logic                           ram_re_o,
  output logic [gremlin_pkg::ADDR_W-1:0] ram_raddr_o,
  input  gremlin_pkg::word_t             ram_rdata_i,
  output logic                           ram_we_o,
  output logic [gremlin_pkg::ADDR_W-1:0] ram_waddr_o,
  output gremlin_pkg::word_t             ram_wdata_o
);
  import gremlin_pkg::*;

  logic              write_q, read_q;  // strobe history
  logic              wr_start, rd_start;
  logic              wr_act, rd_act;
  logic [1:0]        wr_cnt, rd_cnt;
  logic [3:0]        addr_q;
  logic [63:0]       wdata_q;
  word_t             host_word;
  logic [ADDR_W-1:0] host_waddr, host_raddr;
  logic [ADDR_W-1:0] seq_raddr_q;      // last sequencer read
  logic              host_dwe, restore;

  assign wr_start    = host_write_i && !write_q;
  assign rd_start    = host_read_i && !read_q;
  assign host_busy_o = wr_act || rd_act;

  // ------------------------------------------------------------
  // address and data of the burst word
  // ------------------------------------------------------------
  assign host_word  = wdata_q[(HOST_WORDS - 1 - wr_cnt) * 16 +: 16];  // msw first
  assign host_waddr = ADDR_W'({addr_q[2:0], wr_cnt});
  assign host_dwe   = wr_act && !addr_q[3];
  // last read cycle puts the sequencer's operand back on the ram output
  assign restore    = rd_act && (rd_cnt == 2'd2);
  assign host_raddr = restore ? seq_raddr_q : ADDR_W'({addr_q[2:0], 1'b0, rd_cnt[0]});

  assign prog_we_o    = wr_act && addr_q[3];
  assign prog_waddr_o = host_waddr;
  assign prog_wdata_o = instr_t'(host_word);

  // host first on the data ram
  assign ram_re_o    = rd_act || mem.re;
  assign ram_raddr_o = rd_act ? host_raddr : mem.raddr;
  assign ram_we_o    = host_dwe || mem.we;
  assign ram_waddr_o = host_dwe ? host_waddr : mem.waddr;
  assign ram_wdata_o = host_dwe ? host_word : mem.wdata;
  assign mem.rdata   = ram_rdata_i;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      write_q          <= 1'b1;  // no burst from a strobe held through reset
      read_q           <= 1'b1;
      wr_act           <= 1'b0;
      rd_act           <= 1'b0;
      wr_cnt           <= '0;
      rd_cnt           <= '0;
      host_write_ack_o <= 1'b0;
      host_read_ack_o  <= 1'b0;
      seq_raddr_q      <= '0;
    end
    else
    begin
      write_q          <= host_write_i;
      read_q           <= host_read_i;
      host_write_ack_o <= 1'b0;
      host_read_ack_o  <= 1'b0;
      if (wr_start)
      begin
        wr_act <= 1'b1;
        wr_cnt <= '0;
      end
      else if (wr_act)
      begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == 2'(HOST_WORDS - 1))
        begin
          wr_act           <= 1'b0;
          host_write_ack_o <= 1'b1;
        end
      end
      if (rd_start)
      begin
        rd_act <= 1'b1;
        rd_cnt <= '0;
      end
      else if (rd_act)
      begin
        rd_cnt <= rd_cnt + 1'b1;
        if (restore)
        begin
          rd_act          <= 1'b0;
          host_read_ack_o <= 1'b1;
        end
      end
      if (mem.re)
        seq_raddr_q <= mem.raddr;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (wr_start || rd_start)
      addr_q <= host_addr_i;
    if (wr_start)
      wdata_q <= host_wdata_i;
    if (rd_act && (rd_cnt == 2'd1))
      host_rdata_o[15:0] <= ram_rdata_i;   // word 4a
    if (restore)
      host_rdata_o[31:16] <= ram_rdata_i;  // word 4a+1
  end

  // both bursts share the address latch
  a_no_overlap: assert property (@(posedge CLK) disable iff (!RST)
    !(wr_act && rd_act));

  a_write_ack: assert property (@(posedge CLK) disable iff (!RST)
    (wr_start && !wr_act && !rd_act) |-> ##5 host_write_ack_o);

endmodule

//--- hdl/gremlin_mem_if.sv
`timescale 1ns/1ps

interface mem_port_if;
  import gremlin_pkg::*;

  logic              re;
  logic [ADDR_W-1:0] raddr;
  word_t             rdata;
  logic              we;
  logic [ADDR_W-1:0] waddr;
  word_t             wdata;

  // sequencer issues addresses, datapath moves the data
  modport seq_mp (output re, raddr, we, waddr);
  modport dp_mp  (output wdata, input rdata);
  modport arb_mp (input re, raddr, we, waddr, wdata, output rdata);

endinterface

//--- hdl/gremlin_pkg.sv
package gremlin_pkg;

  parameter int ADDR_W     = 8;  // program and data memory
  parameter int HOST_WORDS = 4;  // words per host write burst

  typedef logic [15:0] word_t;

  // ------------------------------------------------------------
  // instruction encoding
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,  // carry in 0
    OP_ADC1   = 4'h1,  // carry in 1
    OP_ADDC   = 4'h2,  // carry in from last add
    OP_LDIN   = 4'h5,
    OP_HALT   = 4'h6,
    OP_STORE  = 4'h8,
    OP_OUT    = 4'ha,
    OP_SETIDX = 4'hc,
    OP_AND    = 4'hd,
    OP_OR     = 4'he,
    OP_XOR    = 4'hf
  } op_e;

  typedef struct packed {
    logic       branch;   // taken when acc is nonzero
    logic [1:0] osel;
    logic       indexed;  // address is index + imm
    op_e        op;
    logic [7:0] imm;
  } instr_t;

  // operand select codes, the upper two need no memory read
  parameter logic [1:0] OSEL_MEM  = 2'd0;
  parameter logic [1:0] OSEL_INV  = 2'd1;
  parameter logic [1:0] OSEL_ZERO = 2'd2;
  parameter logic [1:0] OSEL_ONES = 2'd3;

  parameter instr_t INSTR_NOP = instr_t'(16'h4700);  // zero operand, op 7

endpackage

//--- hdl/gremlin_ram.sv
`timescale 1ns/1ps

module gremlin_ram #(
  parameter int  ADDR_W    = 8,
  parameter type payload_t = logic [15:0]
) (
  input  logic              CLK,
  input  logic              re_i,
  input  logic [ADDR_W-1:0] raddr_i,
  output payload_t          rdata_o,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  payload_t          wdata_i
);

  payload_t mem_q [2**ADDR_W];

  always_ff @(posedge CLK)
  begin
    if (we_i)
      mem_q[waddr_i] <= wdata_i;
  end

  // read on the same edge as a write to that word returns the old word
  always_ff @(posedge CLK)
  begin
    if (re_i)
      rdata_o <= mem_q[raddr_i];  // holds while re_i is low
  end

endmodule

//--- hdl/gremlin_seq.sv
`timescale 1ns/1ps

module gremlin_seq (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           run_i,
  input  logic                           host_busy_i,
  output logic [gremlin_pkg::ADDR_W-1:0] prog_raddr_o,
  output logic                           prog_re_o,
  input  gremlin_pkg::instr_t            prog_rdata_i,
  mem_port_if.seq_mp                     mem,
  output logic                           adv_o,
  output gremlin_pkg::instr_t            instr_op_o,
  output gremlin_pkg::instr_t            instr_ex_o,
  input  logic                           acc_nz_i,
  input  logic [gremlin_pkg::ADDR_W-1:0] index_i,
  output logic                           done_o
);
  import gremlin_pkg::*;

  logic [ADDR_W-1:0] pc;                // address of the fetched word
  logic [ADDR_W-1:0] addr_fe, addr_op, addr_ex;
  logic              take_branch;

  assign adv_o       = run_i && !host_busy_i && !done_o;
  assign take_branch = instr_ex_o.branch && acc_nz_i;  // two delay slots

  // ------------------------------------------------------------
  // fetch
  // ------------------------------------------------------------
  // while stopped, keep word 0 on the program ram output
  assign prog_raddr_o = !run_i ? '0 : (take_branch ? instr_ex_o.imm : pc + 1'b1);
  assign prog_re_o    = adv_o || !run_i;

  // data address is formed at fetch and travels with the instruction
  assign addr_fe = prog_rdata_i.indexed ? index_i + prog_rdata_i.imm : prog_rdata_i.imm;

  assign mem.re    = adv_o && !prog_rdata_i.osel[1];  // zero and ones skip the read
  assign mem.raddr = addr_fe;
  assign mem.we    = adv_o && (instr_ex_o.op == OP_STORE);
  assign mem.waddr = addr_ex;

  always_ff @(posedge CLK)
  begin
    if (!RST || !run_i)
    begin
      pc         <= '0;
      instr_op_o <= INSTR_NOP;
      instr_ex_o <= INSTR_NOP;
      done_o     <= 1'b0;
    end
    else if (adv_o)
    begin
      pc         <= prog_raddr_o;
      instr_op_o <= prog_rdata_i;
      instr_ex_o <= instr_op_o;
      if (instr_ex_o.op == OP_HALT)
        done_o <= 1'b1;                 // stops on this edge
    end
  end

  always_ff @(posedge CLK)
  begin
    if (adv_o)
    begin
      addr_op <= addr_fe;
      addr_ex <= addr_op;
    end
  end

  // a stalled fetch keeps its word on the program ram output
  a_stall_hold: assert property (@(posedge CLK) disable iff (!RST)
    (run_i && !adv_o) |=> $stable(prog_rdata_i));

endmodule

//--- hdl/gremlin_top.sv
`timescale 1ns/1ps

module gremlin_top #(
  parameter int SLOT_LEN = 192,
  parameter int ADDR_W   = gremlin_pkg::ADDR_W
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               run_i,
  input  logic               capture_i,
  input  logic               host_read_i,
  input  logic               host_write_i,
  input  logic [3:0]         host_addr_i,
  input  logic [63:0]        host_wdata_i,
  output logic [31:0]        host_rdata_o,
  output logic               host_read_ack_o,
  output logic               host_write_ack_o,
  input  gremlin_pkg::word_t in_0_i,
  input  gremlin_pkg::word_t in_1_i,
  input  gremlin_pkg::word_t in_2_i,
  input  gremlin_pkg::word_t in_3_i,
  output gremlin_pkg::word_t out_0_o,
  output gremlin_pkg::word_t out_1_o,
  output gremlin_pkg::word_t out_2_o,
  output gremlin_pkg::word_t out_3_o,
  output logic               done_o,
  output logic               refresh_o
);
  import gremlin_pkg::*;

  logic              host_busy, adv, acc_nz;
  logic              prog_we, prog_re, ram_re, ram_we;
  logic [ADDR_W-1:0] prog_waddr, prog_raddr, ram_raddr, ram_waddr, index;
  instr_t            prog_wdata, prog_rdata, instr_op, instr_ex;
  word_t             ram_rdata, ram_wdata;

  mem_port_if mem ();

  // ------------------------------------------------------------
  // host side and memories
  // ------------------------------------------------------------
  gremlin_host_port i_host_port (
    .CLK, .RST, .host_read_i, .host_write_i, .host_addr_i, .host_wdata_i,
    .host_rdata_o, .host_read_ack_o, .host_write_ack_o,
    .host_busy_o  (host_busy),
    .prog_we_o    (prog_we),
    .prog_waddr_o (prog_waddr),
    .prog_wdata_o (prog_wdata),
    .mem          (mem.arb_mp),
    .ram_re_o     (ram_re),
    .ram_raddr_o  (ram_raddr),
    .ram_rdata_i  (ram_rdata),
    .ram_we_o     (ram_we),
    .ram_waddr_o  (ram_waddr),
    .ram_wdata_o  (ram_wdata)
  );

  gremlin_ram #(.ADDR_W(ADDR_W), .payload_t(word_t)) data_ram (
    .CLK, .re_i(ram_re), .raddr_i(ram_raddr), .rdata_o(ram_rdata),
    .we_i(ram_we), .waddr_i(ram_waddr), .wdata_i(ram_wdata)
  );

  gremlin_ram #(.ADDR_W(ADDR_W), .payload_t(instr_t)) prog_ram (
    .CLK, .re_i(prog_re), .raddr_i(prog_raddr), .rdata_o(prog_rdata),
    .we_i(prog_we), .waddr_i(prog_waddr), .wdata_i(prog_wdata)
  );

  // ------------------------------------------------------------
  // sequencer, datapath and refresh timing
  // ------------------------------------------------------------
  gremlin_seq i_seq (
    .CLK, .RST, .run_i, .done_o,
    .host_busy_i  (host_busy),
    .prog_raddr_o (prog_raddr),
    .prog_re_o    (prog_re),
    .prog_rdata_i (prog_rdata),
    .mem          (mem.seq_mp),
    .adv_o        (adv),
    .instr_op_o   (instr_op),
    .instr_ex_o   (instr_ex),
    .acc_nz_i     (acc_nz),
    .index_i      (index)
  );

  gremlin_datapath i_datapath (
    .CLK, .RST, .capture_i,
    .adv_i      (adv),
    .instr_op_i (instr_op),
    .instr_ex_i (instr_ex),
    .mem        (mem.dp_mp),
    .in_0_i, .in_1_i, .in_2_i, .in_3_i,
    .out_0_o, .out_1_o, .out_2_o, .out_3_o,
    .acc_nz_o   (acc_nz),
    .index_o    (index)
  );

  gremlin_carousel #(.SLOT_LEN(SLOT_LEN)) i_carousel (
    .CLK, .RST, .refresh_o,
    .host_busy_i (host_busy)
  );

endmodule

//--- verification/gremlin_tb.sv
`timescale 1ns/1ps

module gremlin_tb;
  import gremlin_pkg::*;

  localparam int SLOT_LEN  = 24;
  localparam int NUM_PROG  = 4;
  localparam int PROG_LEN  = 32;                            // writable program words
  localparam int N_BURSTS  = 8 + 4 + NUM_PROG * (8 + 4 + 3);
  localparam int RUN_MAX   = 160;                           // loop of 8 passes, stalls included
  localparam int REFR_CYC  = 32 * SLOT_LEN + 64;
  localparam int LIMIT     = 16 + N_BURSTS * 14 + NUM_PROG * RUN_MAX + REFR_CYC + 400;

  logic        CLK, RST, run_i, capture_i;
  logic        host_read_i, host_write_i;
  logic [3:0]  host_addr_i;
  logic [63:0] host_wdata_i;
  logic [31:0] host_rdata_o;
  logic        host_read_ack_o, host_write_ack_o;
  word_t       in_0_i, in_1_i, in_2_i, in_3_i;
  word_t       out_0_o, out_1_o, out_2_o, out_3_o;
  logic        done_o, refresh_o;

  int          errors, checks, cycles;
  logic [31:0] rng_state;
  logic [15:0] prog [PROG_LEN];
  // reference model state, kept across programs like the datapath
  word_t       m_mem [256];
  word_t       m_acc, m_out [4], m_in [4];
  logic        m_carry;
  logic [7:0]  m_idx;

  gremlin_top #(.SLOT_LEN(SLOT_LEN)) i_gremlin_top (.*);

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = !CLK;
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("run did not finish within %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [15:0] encode(logic br, logic [1:0] osel, logic idx,
                                         logic [3:0] op, logic [7:0] imm);
    return {br, osel, idx, op, imm};
  endfunction

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic host_write(logic [3:0] addr, logic [63:0] data);
    int n;
    n = 0;
    @(negedge CLK);
    host_addr_i  = addr;
    host_wdata_i = data;
    host_write_i = 1'b1;
    do
    begin
      @(negedge CLK);
      n++;
    end while (!host_write_ack_o);
    compare("write ack cycle", n, 5);  // ack on edge t+5
    host_write_i = 1'b0;
  endtask

  task automatic host_read(logic [3:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(negedge CLK);
    host_addr_i = addr;
    host_read_i = 1'b1;
    do
    begin
      @(negedge CLK);
      n++;
    end while (!host_read_ack_o);
    compare("read ack cycle", n, 4);   // ack on edge t+4
    data        = host_rdata_o;
    host_read_i = 1'b0;
  endtask

  task automatic check_pair(logic [2:0] a);
    logic [31:0] rd;
    host_read({1'b0, a}, rd);
    compare("host_rdata_o[15:0]", rd[15:0], m_mem[{a, 2'b00}]);
    compare("host_rdata_o[31:16]", rd[31:16], m_mem[{a, 2'b01}]);
  endtask

  // ------------------------------------------------------------
  // program generation and reference model
  // ------------------------------------------------------------
  function automatic logic [7:0] result_addr(logic [31:0] r);
    return 8'd16 + {r[1:0], 2'b00} + r[2];  // host-readable words only
  endfunction

  task automatic make_program();
    logic [3:0]  ops [10];
    logic [31:0] r;
    logic [3:0]  op;
    logic        idx;
    ops = '{OP_ADD, OP_ADC1, OP_ADDC, OP_AND, OP_OR, OP_XOR, OP_STORE, OP_OUT, OP_LDIN, 4'h3};
    r        = next_rand();
    prog[0]  = encode(0, OSEL_ZERO, 0, OP_LDIN, r[1:0]);
    prog[1]  = encode(0, OSEL_MEM, 0, OP_AND, 8'd15);      // acc 0..7
    prog[2]  = encode(0, OSEL_ZERO, 0, OP_ADC1, 0);        // loop count 1..8
    prog[3]  = encode(0, OSEL_ONES, 0, OP_ADD, 0);         // decrement
    prog[4]  = encode(1, OSEL_ZERO, 0, 4'h7, 8'd3);
    prog[5]  = encode(0, OSEL_ZERO, 0, OP_STORE, result_addr(r >> 4));  // delay slot
    prog[6]  = encode(0, OSEL_ZERO, 0, OP_OUT, r[9:8]);                 // delay slot
    prog[7]  = encode(0, OSEL_MEM, 0, OP_OR, r[13:10] % 15);
    prog[8]  = encode(0, OSEL_MEM, 0, OP_AND, 8'd15);
    prog[9]  = encode(0, OSEL_ZERO, 0, OP_SETIDX, 0);
    prog[10] = INSTR_NOP;
    prog[11] = INSTR_NOP;
    prog[12] = encode(0, {1'b0, r[14]}, 1, OP_XOR, r[18:16]);
    for (int i = 13; i < 27; i++)
    begin
      r   = next_rand();
      op  = ops[r % 10];
      idx = r[6] && !(op inside {OP_STORE, OP_OUT, OP_LDIN});
      if (op == OP_STORE)
        prog[i] = encode(0, r[5:4], 0, op, result_addr(r >> 8));
      else if (op inside {OP_OUT, OP_LDIN})
        prog[i] = encode(0, r[5:4], 0, op, r[9:8]);
      else
        prog[i] = encode(0, r[5:4], idx, op, idx ? r[10:8] : r[11:8]);
    end
    prog[27] = encode(0, OSEL_ZERO, 0, OP_HALT, 0);
    for (int i = 28; i < PROG_LEN; i++)
      prog[i] = INSTR_NOP;
  endtask

  task automatic run_model();
    int          pc, cnt, steps;
    logic [7:0]  target, addr;
    logic [15:0] ins, opnd;
    logic [16:0] sum;
    logic        taken;
    pc = 0;
    cnt = 0;
    steps = 0;
    target = 0;
    ins = prog[0];
    while (ins[11:8] != OP_HALT && steps < 400)
    begin
      addr = ins[12] ? m_idx + ins[7:0] : ins[7:0];
      case (ins[14:13])
        2'd0:    opnd = m_mem[addr];
        2'd1:    opnd = ~m_mem[addr];
        2'd2:    opnd = 16'h0000;
        default: opnd = 16'hffff;
      endcase
      taken = ins[15] && (m_acc != 0);
      case (ins[11:8])
        OP_ADD, OP_ADC1, OP_ADDC:
        begin
          sum = m_acc + opnd + (ins[11:8] == OP_ADC1 ? 1 :
                                ins[11:8] == OP_ADDC ? m_carry : 0);
          m_acc   = sum[15:0];
          m_carry = sum[16];
        end
        OP_LDIN:   m_acc = m_in[ins[1:0]];
        OP_OUT:    m_out[ins[1:0]] = m_acc;
        OP_SETIDX: m_idx = m_acc[7:0];
        OP_STORE:  m_mem[addr] = m_acc;
        OP_AND:    m_acc = m_acc & opnd;
        OP_OR:     m_acc = m_acc | opnd;
        OP_XOR:    m_acc = m_acc ^ opnd;
        default:   ;
      endcase
      pc++;
      if (cnt > 0)
      begin
        cnt--;
        if (cnt == 0)
          pc = target;   // both delay slots done
      end
      if (taken)
      begin
        target = ins[7:0];
        cnt    = 2;
      end
      steps++;
      ins = prog[pc % PROG_LEN];
    end
    if (steps >= 400)
    begin
      $display("reference model did not reach halt");
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  task automatic capture_inputs();
    @(negedge CLK);
    {in_0_i, in_1_i} = next_rand();
    {in_2_i, in_3_i} = next_rand();
    m_in = '{in_0_i, in_1_i, in_2_i, in_3_i};
    capture_i = 1'b1;
    @(negedge CLK);
    capture_i = 1'b0;
    {in_0_i, in_1_i} = next_rand();  // not captured
    {in_2_i, in_3_i} = next_rand();
  endtask

  task automatic run_program();
    logic [31:0] rd;
    make_program();
    for (int a = 0; a < 8; a++)
      host_write(4'h8 | a, {prog[4*a], prog[4*a+1], prog[4*a+2], prog[4*a+3]});
    run_model();
    @(negedge CLK);
    run_i = 1'b1;
    fork
      while (!done_o)
        @(negedge CLK);
      for (int k = 0; k < 3; k++)
      begin
        repeat (next_rand() % 8) @(negedge CLK);
        check_pair(next_rand() % 4);  // words 0..15 never change
      end
    join
    for (int a = 4; a < 8; a++)
      check_pair(a);
    compare("out_0_o", out_0_o, m_out[0]);
    compare("out_1_o", out_1_o, m_out[1]);
    compare("out_2_o", out_2_o, m_out[2]);
    compare("out_3_o", out_3_o, m_out[3]);
    @(negedge CLK);
    run_i = 1'b0;
  endtask

  task automatic check_refresh();
    int   toggles;
    logic last;
    repeat (10) @(negedge CLK);
    toggles = 0;
    last    = refresh_o;
    repeat (32 * SLOT_LEN)
    begin
      @(negedge CLK);
      if (refresh_o != last)
        toggles++;
      last = refresh_o;
    end
    compare("refresh toggles", toggles, 16);  // one per odd frame
  endtask

  initial
  begin
    logic [63:0] data;
    errors = 0;
    checks = 0;
    cycles = 0;
    rng_state = 32'd62417;
    RST = 1'b0;
    {run_i, capture_i, host_read_i, host_write_i} = '0;
    host_addr_i = '0;
    host_wdata_i = '0;
    {in_0_i, in_1_i, in_2_i, in_3_i} = '0;
    m_acc = '0;
    m_carry = 1'b0;
    m_idx = '0;
    m_out = '{default: '0};
    m_in  = '{default: '0};
    repeat (16) @(negedge CLK);
    RST = 1'b1;
    compare("host_write_ack_o", host_write_ack_o, 0);
    compare("host_read_ack_o", host_read_ack_o, 0);
    compare("done_o", done_o, 0);
    compare("refresh_o", refresh_o, 0);
    compare("out_0_o", out_0_o, 0);
    compare("out_3_o", out_3_o, 0);

    for (int a = 0; a < 8; a++)
    begin
      data = {next_rand(), next_rand()};
      if (a == 3)
        data[15:0] = 16'h0007;   // word 15 is the index mask
      {m_mem[4*a], m_mem[4*a+1], m_mem[4*a+2], m_mem[4*a+3]} = data;
      host_write(a, data);
    end
    for (int a = 0; a < 4; a++)
      check_pair(a);

    for (int k = 0; k < NUM_PROG; k++)
    begin
      capture_inputs();
      run_program();
    end
    check_refresh();

    $display("errors: %0d of %0d checks, %0d cycles", errors, checks, cycles);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
